//--- src/multdiv_settings.svh
// Width settings for the RV32M multiply and divide unit
// Operand width, partial product half width and divide step counter width

`ifndef MULTDIV_SETTINGS_SVH
`define MULTDIV_SETTINGS_SVH

// Operand and result width
`define MD_XLEN 32

// Half word used by the 17x17 multiply-accumulate
`define MD_HALF 16

// Counts the 32 compare-subtract steps of the divider
`define MD_CNT_W 5

`endif

//--- src/multdiv_pkg.sv
// Shared types of the multiply and divide unit
// Opcode enum in funct3 order and the step enums of both sequencers

package multdiv_pkg;

  // RV32M opcodes, values follow funct3
  typedef enum logic [2:0] {
    MD_OP_MUL    = 3'd0,
    MD_OP_MULH   = 3'd1,
    MD_OP_MULHSU = 3'd2,
    MD_OP_MULHU  = 3'd3,
    MD_OP_DIV    = 3'd4,
    MD_OP_DIVU   = 3'd5,
    MD_OP_REM    = 3'd6,
    MD_OP_REMU   = 3'd7
  } md_op_e;

  // Partial product steps of the multiplier
  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  // Long division steps
  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_CHANGE_SIGN, DIV_FINISH
  } div_state_e;

endpackage

//--- src/multdiv_mac.sv
// Multi-cycle multiplier built on one signed 17x17 multiply-accumulate
// Steps through AL*BL, AL*BH, AH*BL and AH*BH

`timescale 1ns/1ps
`include "multdiv_settings.svh"

module multdiv_mac (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  logic                high_part_i,
  input  logic                sign_a_i,
  input  logic                sign_b_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  input  logic                ack_i,
  output logic                done_o,
  output logic [`MD_XLEN-1:0] result_o
);

  multdiv_pkg::mult_state_e state_q;
  multdiv_pkg::mult_state_e state_d;
  logic                     done_q;
  logic                     step;
  logic                     last_step;
  logic                     signed_mult;

  logic [`MD_HALF-1:0]      mul_op_a;
  logic [`MD_HALF-1:0]      mul_op_b;
  logic                     mul_sign_a;
  logic                     mul_sign_b;
  logic [2*`MD_HALF+1:0]    accum;
  logic [2*`MD_HALF+1:0]    acc_q;
  logic [2*`MD_HALF+1:0]    acc_d;
  logic signed [2*`MD_HALF+1:0] mac_res;

  // Top two bits of the full 35-bit sum always match, so 34 bits are enough
  assign mac_res = $signed({mul_sign_a, mul_op_a}) * $signed({mul_sign_b, mul_op_b})
                 + $signed(accum);

  assign signed_mult = sign_a_i | sign_b_i;

  // Idle in ALBL until started, then one step per cycle until done
  assign step = ~done_q & ((state_q != multdiv_pkg::ALBL) | start_i);

  always_comb begin
    mul_op_a   = op_a_i[`MD_HALF-1:0];
    mul_op_b   = op_b_i[`MD_HALF-1:0];
    mul_sign_a = 1'b0;
    mul_sign_b = 1'b0;
    accum      = acc_q;
    acc_d      = mac_res;
    state_d    = state_q;
    last_step  = 1'b0;

    case (state_q)
      multdiv_pkg::ALBL: begin
        accum   = '0;
        state_d = multdiv_pkg::ALBH;
      end

      multdiv_pkg::ALBH: begin
        mul_op_b   = op_b_i[`MD_XLEN-1:`MD_HALF];
        mul_sign_b = sign_b_i & op_b_i[`MD_XLEN-1];
        // AL*BL is unsigned and has no carry out of bit 31
        accum      = {{(`MD_HALF+2){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
        if (!high_part_i) begin
          acc_d = {2'b00, mac_res[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
        end
        state_d    = multdiv_pkg::AHBL;
      end

      multdiv_pkg::AHBL: begin
        mul_op_a   = op_a_i[`MD_XLEN-1:`MD_HALF];
        mul_sign_a = sign_a_i & op_a_i[`MD_XLEN-1];
        if (!high_part_i) begin
          // Low word done, bits 15:0 were kept from the first step
          accum     = {{(`MD_HALF+2){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
          acc_d     = {2'b00, mac_res[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
          last_step = 1'b1;
        end else begin
          state_d = multdiv_pkg::AHBH;
        end
      end

      multdiv_pkg::AHBH: begin
        mul_op_a   = op_a_i[`MD_XLEN-1:`MD_HALF];
        mul_op_b   = op_b_i[`MD_XLEN-1:`MD_HALF];
        mul_sign_a = sign_a_i & op_a_i[`MD_XLEN-1];
        mul_sign_b = sign_b_i & op_b_i[`MD_XLEN-1];
        // Shift the running sum down by a half word, extending its sign
        accum      = {{`MD_HALF{signed_mult & acc_q[2*`MD_HALF+1]}},
                      acc_q[2*`MD_HALF+1:`MD_HALF]};
        last_step  = 1'b1;
      end

      default: begin
        state_d = multdiv_pkg::ALBL;
      end
    endcase
  end

  // The last step keeps its state until the result is acknowledged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= multdiv_pkg::ALBL;
      done_q  <= 1'b0;
    end else if (done_q) begin
      if (ack_i) begin
        done_q  <= 1'b0;
        state_q <= multdiv_pkg::ALBL;
      end
    end else if (step) begin
      state_q <= state_d;
      done_q  <= last_step;
    end
  end

  always_ff @(posedge clk_i) begin
    if (step) begin
      acc_q <= acc_d;
    end
  end

  assign done_o   = done_q;
  assign result_o = acc_q[`MD_XLEN-1:0];

endmodule

//--- src/multdiv_divider.sv
// Restoring long-division sequencer for DIV, DIVU, REM and REMU
// Owns a 33-bit subtractor for absolute values, compare-subtract and negation

`timescale 1ns/1ps
`include "multdiv_settings.svh"

module multdiv_divider (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  logic                want_rem_i,
  input  logic                sign_a_i,
  input  logic                sign_b_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  input  logic                ack_i,
  output logic                done_o,
  output logic [`MD_XLEN-1:0] result_o
);

  multdiv_pkg::div_state_e state_q;
  multdiv_pkg::div_state_e state_d;
  logic [`MD_CNT_W-1:0]    cnt_q;
  logic [`MD_CNT_W-1:0]    cnt_d;

  logic [`MD_XLEN-1:0]     num_q;
  logic [`MD_XLEN-1:0]     num_d;
  logic [`MD_XLEN-1:0]     den_q;
  logic [`MD_XLEN-1:0]     den_d;
  logic [`MD_XLEN-1:0]     quo_q;
  logic [`MD_XLEN-1:0]     quo_d;
  logic [`MD_XLEN-1:0]     rem_q;
  logic [`MD_XLEN-1:0]     rem_d;

  logic [`MD_XLEN-1:0]     sub_a;
  logic [`MD_XLEN-1:0]     sub_b;
  logic [`MD_XLEN:0]       sub_res;
  logic                    is_greater_equal;
  logic [`MD_XLEN-1:0]     next_rem;
  logic [`MD_XLEN-1:0]     next_quo;
  logic [`MD_XLEN-1:0]     one_shift;

  logic                    b_zero;
  logic                    div_sign_a;
  logic                    div_sign_b;
  logic                    div_change_sign;
  logic                    rem_change_sign;

  // Borrow out of bit 32 means the remainder is below the divisor
  assign sub_res          = {1'b0, sub_a} - {1'b0, sub_b};
  assign is_greater_equal = ~sub_res[`MD_XLEN];

  assign one_shift = `MD_XLEN'(1) << cnt_q;
  assign next_rem  = is_greater_equal ? sub_res[`MD_XLEN-1:0] : rem_q;
  assign next_quo  = is_greater_equal ? (quo_q | one_shift) : quo_q;

  assign b_zero          = ~|op_b_i;
  assign div_sign_a      = sign_a_i & op_a_i[`MD_XLEN-1];
  assign div_sign_b      = sign_b_i & op_b_i[`MD_XLEN-1];
  assign div_change_sign = (div_sign_a ^ div_sign_b) & ~b_zero;
  // Remainder follows the sign of the dividend
  assign rem_change_sign = div_sign_a;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    num_d   = num_q;
    den_d   = den_q;
    quo_d   = quo_q;
    rem_d   = rem_q;
    sub_a   = rem_q;
    sub_b   = den_q;

    case (state_q)
      multdiv_pkg::DIV_IDLE: begin
        if (start_i) begin
          // Preload the divide-by-zero answer, used only when b is zero
          rem_d   = want_rem_i ? op_a_i : '1;
          state_d = b_zero ? multdiv_pkg::DIV_FINISH : multdiv_pkg::DIV_ABS_A;
        end
      end

      multdiv_pkg::DIV_ABS_A: begin
        sub_a   = '0;
        sub_b   = op_a_i;
        num_d   = div_sign_a ? sub_res[`MD_XLEN-1:0] : op_a_i;
        quo_d   = '0;
        state_d = multdiv_pkg::DIV_ABS_B;
      end

      multdiv_pkg::DIV_ABS_B: begin
        sub_a   = '0;
        sub_b   = op_b_i;
        den_d   = div_sign_b ? sub_res[`MD_XLEN-1:0] : op_b_i;
        rem_d   = {{(`MD_XLEN-1){1'b0}}, num_q[`MD_XLEN-1]};
        cnt_d   = '1;
        state_d = multdiv_pkg::DIV_COMP;
      end

      multdiv_pkg::DIV_COMP: begin
        cnt_d   = cnt_q - 1'b1;
        // Shift the next numerator bit into the remainder
        rem_d   = {next_rem[`MD_XLEN-2:0], num_q[cnt_d]};
        quo_d   = next_quo;
        state_d = (cnt_q == `MD_CNT_W'(1)) ? multdiv_pkg::DIV_LAST : multdiv_pkg::DIV_COMP;
      end

      multdiv_pkg::DIV_LAST: begin
        // Bit 0 step, the remainder register now carries the wanted result
        rem_d   = want_rem_i ? next_rem : next_quo;
        quo_d   = next_quo;
        state_d = multdiv_pkg::DIV_CHANGE_SIGN;
      end

      multdiv_pkg::DIV_CHANGE_SIGN: begin
        sub_a = '0;
        sub_b = rem_q;
        if (want_rem_i ? rem_change_sign : div_change_sign) begin
          rem_d = sub_res[`MD_XLEN-1:0];
        end
        state_d = multdiv_pkg::DIV_FINISH;
      end

      multdiv_pkg::DIV_FINISH: begin
        // Hold the result until it is taken
        if (ack_i) begin
          state_d = multdiv_pkg::DIV_IDLE;
        end
      end

      default: begin
        state_d = multdiv_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= multdiv_pkg::DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    num_q <= num_d;
    den_q <= den_d;
    quo_q <= quo_d;
    rem_q <= rem_d;
  end

  assign done_o   = (state_q == multdiv_pkg::DIV_FINISH);
  assign result_o = rem_q;

endmodule

//--- src/multdiv_top.sv
// Top level of the RV32M multiply and divide unit
// Request capture, opcode decode, start pulse and result handshake

`timescale 1ns/1ps
`include "multdiv_settings.svh"

module multdiv_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  multdiv_pkg::md_op_e op_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  output logic                result_valid_o,
  input  logic                result_ready_i,
  output logic [`MD_XLEN-1:0] result_o
);

  logic                busy_q;
  logic                start_q;
  logic                accept;
  logic                result_taken;
  multdiv_pkg::md_op_e op_q;
  logic [`MD_XLEN-1:0] a_q;
  logic [`MD_XLEN-1:0] b_q;

  logic                sign_a;
  logic                sign_b;
  logic                div_sel;
  logic                high_part;
  logic                want_rem;

  logic                mult_start;
  logic                div_start;
  logic                mult_done;
  logic                div_done;
  logic [`MD_XLEN-1:0] mult_result;
  logic [`MD_XLEN-1:0] div_result;

  // One request in flight, ready again once the result is taken
  assign req_ready_o  = ~busy_q;
  assign accept       = req_valid_i & req_ready_o;
  assign result_taken = result_valid_o & result_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      op_q    <= multdiv_pkg::MD_OP_MUL;
    end else begin
      start_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
        op_q   <= op_i;
      end else if (result_taken) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_q <= op_a_i;
      b_q <= op_b_i;
    end
  end

  // Sign modes and unit choice
  always_comb begin
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    div_sel   = 1'b0;
    high_part = 1'b0;
    want_rem  = 1'b0;
    case (op_q)
      multdiv_pkg::MD_OP_MULH: begin
        sign_a    = 1'b1;
        sign_b    = 1'b1;
        high_part = 1'b1;
      end
      multdiv_pkg::MD_OP_MULHSU: begin
        sign_a    = 1'b1;
        high_part = 1'b1;
      end
      multdiv_pkg::MD_OP_MULHU: begin
        high_part = 1'b1;
      end
      multdiv_pkg::MD_OP_DIV: begin
        sign_a  = 1'b1;
        sign_b  = 1'b1;
        div_sel = 1'b1;
      end
      multdiv_pkg::MD_OP_DIVU: begin
        div_sel = 1'b1;
      end
      multdiv_pkg::MD_OP_REM: begin
        sign_a   = 1'b1;
        sign_b   = 1'b1;
        div_sel  = 1'b1;
        want_rem = 1'b1;
      end
      multdiv_pkg::MD_OP_REMU: begin
        div_sel  = 1'b1;
        want_rem = 1'b1;
      end
      default: ;
    endcase
  end

  // Start pulse goes to exactly one unit
  assign mult_start = start_q & ~div_sel;
  assign div_start  = start_q & div_sel;

  multdiv_mac u_mac (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (mult_start),
    .high_part_i (high_part),
    .sign_a_i    (sign_a),
    .sign_b_i    (sign_b),
    .op_a_i      (a_q),
    .op_b_i      (b_q),
    .ack_i       (result_ready_i),
    .done_o      (mult_done),
    .result_o    (mult_result)
  );

  multdiv_divider u_div (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (div_start),
    .want_rem_i (want_rem),
    .sign_a_i   (sign_a),
    .sign_b_i   (sign_b),
    .op_a_i     (a_q),
    .op_b_i     (b_q),
    .ack_i      (result_ready_i),
    .done_o     (div_done),
    .result_o   (div_result)
  );

  assign result_valid_o = div_sel ? div_done : mult_done;
  assign result_o       = div_sel ? div_result : mult_result;

endmodule

//--- dv/multdiv_chk.sv
// Bound assertions for the multiply and divide unit
// Handshake exclusivity, result stability and legal sequencer states

`timescale 1ns/1ps
`include "multdiv_settings.svh"

module multdiv_chk (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     req_ready_i,
  input logic                     result_valid_i,
  input logic                     result_ready_i,
  input logic [`MD_XLEN-1:0]      result_i,
  input multdiv_pkg::mult_state_e mult_state_i,
  input multdiv_pkg::div_state_e  div_state_i
);

  // A new request is never offered while a result is pending
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_ready_i && result_valid_i))
    else $error("req_ready_o and result_valid_o are high together");

  // Result holds under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_valid_i && !result_ready_i) |=> (result_valid_i && $stable(result_i)))
    else $error("result_o changed or result_valid_o dropped before the result was taken");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(mult_state_i))
    else $error("multiplier state register holds an unknown value");

  // DIV_FINISH is the highest legal divider step
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(div_state_i) && (div_state_i <= multdiv_pkg::DIV_FINISH))
    else $error("divider state register holds an illegal value");

endmodule

bind multdiv_top multdiv_chk u_chk (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_ready_i    (req_ready_o),
  .result_valid_i (result_valid_o),
  .result_ready_i (result_ready_i),
  .result_i       (result_o),
  .mult_state_i   (u_mac.state_q),
  .div_state_i    (u_div.state_q)
);

//--- dv/multdiv_tb.sv
// Testbench for the RV32M multiply and divide unit
// Clock, reset, LCG stimulus, reference model and result checking

`timescale 1ns/1ps
`include "multdiv_settings.svh"

module multdiv_tb;

  localparam int req_timeout    = 20;
  localparam int result_timeout = 100;
  localparam int num_random     = 400;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  logic                req_ready;
  multdiv_pkg::md_op_e req_op;
  logic [`MD_XLEN-1:0] op_a;
  logic [`MD_XLEN-1:0] op_b;
  logic                result_valid;
  logic                result_ready;
  logic [`MD_XLEN-1:0] result;

  logic [`MD_XLEN-1:0] exp_q[$];
  string               name_q[$];
  logic [`MD_XLEN-1:0] mon_exp;
  string               mon_name;
  int                  num_sent = 0;
  int                  num_checked = 0;
  logic [31:0]         lcg_state = 32'd50022;

  // Zero, one, minus one, extremes and a small pair of mixed sign
  logic [`MD_XLEN-1:0] corners [7] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                       32'h8000_0000, 32'h7fff_ffff, 32'hffff_fff9,
                                       32'h0000_0003};

  multdiv_top uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .op_i           (req_op),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready),
    .result_o       (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper halves of two draws, the low LCG bits are weak
  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  // RV32M result from 64-bit arithmetic
  function automatic logic [`MD_XLEN-1:0] ref_result(input multdiv_pkg::md_op_e op,
                                                     input logic [`MD_XLEN-1:0] a,
                                                     input logic [`MD_XLEN-1:0] b);
    logic signed [2*`MD_XLEN-1:0] sa;
    logic signed [2*`MD_XLEN-1:0] sb;
    logic signed [2*`MD_XLEN-1:0] ua;
    logic signed [2*`MD_XLEN-1:0] ub;
    logic signed [2*`MD_XLEN-1:0] wide;
    sa = {{`MD_XLEN{a[`MD_XLEN-1]}}, a};
    sb = {{`MD_XLEN{b[`MD_XLEN-1]}}, b};
    ua = {{`MD_XLEN{1'b0}}, a};
    ub = {{`MD_XLEN{1'b0}}, b};
    case (op)
      multdiv_pkg::MD_OP_MUL:    wide = sa * sb;
      multdiv_pkg::MD_OP_MULH:   wide = (sa * sb) >> `MD_XLEN;
      multdiv_pkg::MD_OP_MULHSU: wide = (sa * ub) >> `MD_XLEN;
      multdiv_pkg::MD_OP_MULHU:  wide = (ua * ub) >> `MD_XLEN;
      // Division by zero gives all ones, remainder by zero gives the dividend
      multdiv_pkg::MD_OP_DIV:    wide = (b == '0) ? -1 : sa / sb;
      multdiv_pkg::MD_OP_DIVU:   wide = (b == '0) ? '1 : ua / ub;
      multdiv_pkg::MD_OP_REM:    wide = (b == '0) ? ua : sa % sb;
      default:                   wide = (b == '0) ? ua : ua % ub;
    endcase
    return wide[`MD_XLEN-1:0];
  endfunction

  // One request, wait for the result, hold it for a while, then take it
  task automatic run_op(input multdiv_pkg::md_op_e op, input logic [`MD_XLEN-1:0] a,
                        input logic [`MD_XLEN-1:0] b, input string tag, input int hold);
    int                  waited;
    int                  cycles;
    int                  lat;
    string               name;
    logic [`MD_XLEN-1:0] held;
    name = $sformatf("%s %s a=%08h b=%08h", tag, op.name(), a, b);
    req_valid <= 1'b1;
    req_op    <= op;
    op_a      <= a;
    op_b      <= b;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > req_timeout) fail_now("Timeout: the DUT did not accept a request");
    end while (!req_ready);
    req_valid <= 1'b0;
    exp_q.push_back(ref_result(op, a, b));
    name_q.push_back(name);
    num_sent++;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > result_timeout) fail_now("Timeout: no result came back from the DUT");
    end while (!result_valid);
    // Acceptance cycle counts as cycle 0
    if (op <= multdiv_pkg::MD_OP_MULHU) begin
      lat = (op == multdiv_pkg::MD_OP_MUL) ? 4 : 5;
      assert (cycles == lat) else begin
        fail_now($sformatf("[FAIL] %s latency expected %0d actual %0d", name, lat, cycles));
      end
    end
    held = result;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      assert (result_valid && !req_ready && result == held) else begin
        fail_now($sformatf("[FAIL] %s held result expected %08h actual %08h (valid=%0b ready=%0b)",
                           name, held, result, result_valid, req_ready));
      end
    end
    result_ready <= 1'b1;
    @(posedge clk);
    result_ready <= 1'b0;
  endtask

  // Compares every result at the edge where it is taken
  always @(posedge clk) begin
    if (rst_n && result_valid && result_ready) begin
      mon_exp  = exp_q.pop_front();
      mon_name = name_q.pop_front();
      assert (result == mon_exp) else begin
        fail_now($sformatf("[FAIL] %s expected %08h actual %08h", mon_name, mon_exp, result));
      end
      num_checked++;
    end
  end

  initial begin
    multdiv_pkg::md_op_e op;
    logic [`MD_XLEN-1:0] a;
    logic [`MD_XLEN-1:0] b;
    logic [31:0]         r;
    rst_n        <= 1'b0;
    req_valid    <= 1'b0;
    req_op       <= multdiv_pkg::MD_OP_MUL;
    op_a         <= '0;
    op_b         <= '0;
    result_ready <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (req_ready && !result_valid) else begin
      fail_now($sformatf("[FAIL] reset expected ready=1 valid=0 actual ready=%0b valid=%0b",
                         req_ready, result_valid));
    end

    // Every opcode on every pair of corner values
    for (int k = 0; k < 8; k++) begin
      for (int i = 0; i < 7; i++) begin
        for (int j = 0; j < 7; j++) begin
          run_op(multdiv_pkg::md_op_e'(k), corners[i], corners[j], "directed", 0);
        end
      end
    end

    // Back-pressure sweep over 0 to 7 held cycles
    for (int h = 0; h < 8; h++) begin
      a = rand_word();
      b = rand_word();
      run_op(multdiv_pkg::MD_OP_MULH, a, b, "backpressure", h);
      run_op(multdiv_pkg::MD_OP_REM, a, b, "backpressure", h);
    end

    for (int n = 0; n < num_random; n++) begin
      r  = rand_word();
      op = multdiv_pkg::md_op_e'(r[2:0]);
      a  = rand_word();
      b  = rand_word();
      // Bias some draws toward zero divisors, minus one, overflow and tiny divisors
      case (r[5:3])
        3'd0:    b = '0;
        3'd1:    b = '1;
        3'd2:    a = 32'h8000_0000;
        3'd3:    b = {28'b0, r[9:6]};
        default: ;
      endcase
      run_op(op, a, b, "random", int'(r[12:10]));
    end

    @(posedge clk);
    @(posedge clk);
    if (exp_q.size() == 0 && num_checked == num_sent) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_now($sformatf("Only %0d of %0d accepted requests produced a checked result",
                         num_checked, num_sent));
    end
  end

endmodule

//--- multdiv.f
+incdir+src
src/multdiv_pkg.sv
src/multdiv_mac.sv
src/multdiv_divider.sv
src/multdiv_top.sv
dv/multdiv_chk.sv
dv/multdiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the multdiv testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f multdiv.f --top-module multdiv_tb -o multdiv_sim \
  || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/multdiv_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "^TEST PASSED$" && exit 0 || exit 1
